// ==== build.f ====
+incdir+include
rtl/armInstrPkg.sv
rtl/uopSeqPkg.sv
rtl/instrDecoder.sv
rtl/regListTracker.sv
rtl/uopFsm.sv
rtl/uopEncoder.sv
rtl/microOpSequencer.sv
verification/microOpSequencer_asserts.sv
verification/microOpSequencerTb.sv

// ==== include/seqRefModel.svh ====
`ifndef SEQ_REF_MODEL_SVH
`define SEQ_REF_MODEL_SVH

// Flags packed as {instrMux, doNotUpdateFlag, ldmStmForward, prevRsrState, keepV}
typedef struct {
	int count;
	armInstrPkg::instrWord word [17]; // Up to 16 transfers plus base update
	uopSeqPkg::rzCtrl rz [17];
	logic [4:0] flags [17];
} seriesExp;

function automatic void pushStep(inout seriesExp s, input armInstrPkg::instrWord w,
	input uopSeqPkg::rzCtrl rz, input logic [4:0] fl);
	s.word[s.count] = w;
	s.rz[s.count] = rz;
	s.flags[s.count] = fl;
	s.count++;
endfunction

// Empty register lists are not modelled
function automatic seriesExp expectSeries(armInstrPkg::instrWord instr);
	seriesExp s;
	logic [3:0] cond;
	int n;
	int offs;
	bit first;
	s.count = 0;
	cond = instr[31:28];
	n = $countones(instr[15:0]);
	first = 1'b1;
	if (instr[27:21] == 7'b0000001 && instr[7:4] == 4'b1001) begin // MLA
		pushStep(s, {cond, 8'h00, 4'hf, 4'h0, instr[11:0]}, 4'b1100, 5'b10001);
		pushStep(s, {cond, 7'b0000100, instr[20], 4'hf, instr[19:16], 8'h00, instr[15:12]},
			4'b0001, 5'b11010);
	end else if (instr[27:25] == 3'b000 && !instr[7] && instr[4]
		&& instr[27:6] != {8'h12, 12'hfff, 2'b00}) begin // RSR
		pushStep(s, {cond, 7'b0001101, 5'd0, 4'hf, instr[11:0]}, 4'b1100, 5'b11000);
		pushStep(s, {instr[31:12], 8'h00, 4'hf}, 4'b0010, 5'b10010);
	end else if (instr[27:24] == 4'b1011 || instr[27:4] == 24'h12fff3) begin // BL, BLX
		pushStep(s, {cond, 7'b0010010, 1'b0, 8'hfe, 12'd4}, 4'b0000, 5'b10000);
		if (instr[27:24] == 4'b1011)
			pushStep(s, {instr[31:25], 1'b0, instr[23:0]}, 4'b0000, 5'b10000);
		else
			pushStep(s, {instr[31:6], 1'b0, instr[4:0]}, 4'b0000, 5'b10000);
	end else if (instr[27:25] == 3'b100) begin // LDM, STM
		case (instr[24:23])
			2'b00: offs = (n - 1) * 4;
			2'b01: offs = 0;
			2'b10: offs = n * 4;
			default: offs = 4;
		endcase
		for (int r = 0; r < 16; r++) begin
			if (instr[r] && first)
				pushStep(s, {cond, 4'b0101, instr[23], 2'b00, instr[20], instr[19:16], 4'(r),
					12'(offs)}, 4'b0000, 5'b11000);
			else if (instr[r])
				pushStep(s, {cond, 5'b01011, 2'b00, instr[20], 4'hf, 4'(r), 12'd4}, 4'b0001,
					5'b11100);
			if (instr[r])
				first = 1'b0;
		end
		if (n == 1)
			pushStep(s, {4'hf, 7'b0010100, 21'd0}, 4'b0000, 5'b11000);
		else if (instr[21])
			pushStep(s, {cond, 4'b0010, instr[23], ~instr[23], 2'b00, instr[19:16],
				instr[19:16], 4'hf, 3'd0, 5'(n)}, 4'b0000, 5'b11000);
	end else begin
		pushStep(s, instr, 4'b0000, 5'b00000);
	end
	return s;
endfunction

`endif

// ==== verification/microOpSequencerTb.sv ====
`default_nettype none

module microOpSequencerTb;
	`include "seqRefModel.svh"

	localparam int resetCycles = 4;
	localparam int plainCount = 40; // Random ordinary words
	localparam int pairCount = 6; // Rounds of RSR, MLA, BL and BLX
	localparam int blockCount = 8; // LDM/STM per addressing mode
	localparam int singleCount = 8; // One-register lists
	localparam int stallCount = 30; // Mixed words under back-pressure
	localparam int maxSeries = 17; // 16 transfers and the base update
	// Stalls come about one cycle in four, so four times the worst series is ample
	localparam int cycleLimit = resetCycles + plainCount + pairCount * 4 * 2
		+ (blockCount * 4 + 1) * maxSeries + singleCount * 2
		+ stallCount * maxSeries * 4 + 100;

	logic clk;
	logic reset;
	armInstrPkg::instrWord defaultInstr;
	logic stallUop;
	logic instrMux;
	logic doNotUpdateFlag;
	logic uOpStall;
	logic ldmStmForward;
	logic prevRsrState;
	logic keepV;
	uopSeqPkg::rzCtrl regFileRz;
	armInstrPkg::instrWord uOpInstr;

	int seed;
	int pos; // Position inside the running series
	int cycleCount;
	seriesExp expected;

	microOpSequencer dut_i (
		.clk(clk),
		.reset(reset),
		.defaultInstr(defaultInstr),
		.stallUop(stallUop),
		.instrMux(instrMux),
		.doNotUpdateFlag(doNotUpdateFlag),
		.uOpStall(uOpStall),
		.ldmStmForward(ldmStmForward),
		.prevRsrState(prevRsrState),
		.keepV(keepV),
		.regFileRz(regFileRz),
		.uOpInstr(uOpInstr)
	);

	always #20 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input armInstrPkg::instrWord got,
		input armInstrPkg::instrWord want);
		if (got !== want)
			abortRun($sformatf("mismatch %s got %h expected %h", name, got, want));
	endtask

	task automatic checkRz(input string name, input uopSeqPkg::rzCtrl got,
		input uopSeqPkg::rzCtrl want);
		if (got !== want)
			abortRun($sformatf("mismatch %s got %h expected %h", name, got, want));
	endtask

	task automatic checkFlag(input string name, input logic got, input logic want);
		if (got !== want)
			abortRun($sformatf("mismatch %s got %h expected %h", name, got, want));
	endtask

	// Any class the sequencer leaves alone
	function automatic armInstrPkg::instrWord makePlain();
		armInstrPkg::instrWord w;
		w = $random(seed);
		if (w[27:25] inside {3'b000, 3'b100, 3'b101})
			w[26] = 1'b1; // Moves to 010, 110 or 111
		return w;
	endfunction

	function automatic armInstrPkg::instrWord makeRsr();
		armInstrPkg::instrWord w;
		w = $random(seed);
		w[27:25] = 3'b000;
		w[7] = 1'b0; // Keeps multiplies out
		w[4] = 1'b1; // Shift by register
		return w;
	endfunction

	function automatic armInstrPkg::instrWord makeMla();
		armInstrPkg::instrWord w;
		w = $random(seed);
		w[27:21] = 7'b0000001;
		w[7:4] = 4'b1001;
		return w;
	endfunction

	function automatic armInstrPkg::instrWord makeBl();
		armInstrPkg::instrWord w;
		w = $random(seed);
		w[27:24] = 4'b1011;
		return w;
	endfunction

	function automatic armInstrPkg::instrWord makeBlx();
		armInstrPkg::instrWord w;
		w = $random(seed);
		w[27:4] = 24'h12fff3; // Register form, Rm stays random
		return w;
	endfunction

	// Random list of two or more registers, W bit left random
	function automatic armInstrPkg::instrWord makeBlock(input logic [1:0] mode);
		armInstrPkg::instrWord w;
		w = $random(seed);
		w[27:25] = 3'b100;
		w[24:23] = mode; // P and U
		if ($countones(w[15:0]) < 2)
			w[15:0] = w[15:0] | 16'h0101;
		return w;
	endfunction

	function automatic armInstrPkg::instrWord makeSingle();
		armInstrPkg::instrWord w;
		logic [3:0] r;
		w = $random(seed);
		r = 4'($random(seed));
		w[27:25] = 3'b100;
		w[15:0] = 16'd1 << r;
		return w;
	endfunction

	function automatic armInstrPkg::instrWord makeAny();
		logic [2:0] sel;
		sel = 3'($random(seed));
		case (sel)
			3'd0: return makePlain();
			3'd1: return makeRsr();
			3'd2: return makeMla();
			3'd3: return makeBl();
			3'd4: return makeBlx();
			3'd5, 3'd6: return makeBlock(2'($random(seed)));
			default: return makeSingle();
		endcase
	endfunction

	// Hold the word until the DUT drops uOpStall on an unstalled edge
	task automatic runInstr(input armInstrPkg::instrWord instr, input bit withStall);
		bit accepted;
		@(negedge clk);
		defaultInstr = instr;
		stallUop = withStall && (($random(seed) & 3) == 0);
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			accepted = !uOpStall && !stallUop;
			if (!accepted) begin
				@(negedge clk);
				stallUop = withStall && (($random(seed) & 3) == 0);
			end
		end
	endtask

	// Compare every edge; a held edge repeats the same entry
	always @(posedge clk) begin
		if (reset) begin
			pos = 0;
		end else begin
			if (dut_i.fsm_i.asserts_i.failCount != 0)
				abortRun("a protocol assertion failed");
			if (pos == 0)
				expected = expectSeries(defaultInstr);
			checkWord("uOpInstr", uOpInstr, expected.word[pos]);
			checkRz("regFileRz", regFileRz, expected.rz[pos]);
			checkFlag("instrMux", instrMux, expected.flags[pos][4]);
			checkFlag("doNotUpdateFlag", doNotUpdateFlag, expected.flags[pos][3]);
			checkFlag("ldmStmForward", ldmStmForward, expected.flags[pos][2]);
			checkFlag("prevRsrState", prevRsrState, expected.flags[pos][1]);
			checkFlag("keepV", keepV, expected.flags[pos][0]);
			checkFlag("uOpStall", uOpStall, pos < expected.count - 1); // Low on the last
			if (!stallUop) begin
				pos++;
				if (pos == expected.count)
					pos = 0; // Next word starts a new series
			end
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit)
			abortRun($sformatf("run timed out after %0d cycles", cycleCount));
	end

	initial begin
		seed = 32'h7c38;
		cycleCount = 0;
		pos = 0;
		clk = 1'b0;
		reset = 1'b1;
		stallUop = 1'b0;
		defaultInstr = 32'he1a00000; // MOV r0, r0
		repeat (resetCycles) @(negedge clk);
		reset = 1'b0;
		repeat (plainCount) runInstr(makePlain(), 1'b0);
		repeat (pairCount) begin
			runInstr(makeRsr(), 1'b0);
			runInstr(makeMla(), 1'b0);
			runInstr(makeBl(), 1'b0);
			runInstr(makeBlx(), 1'b0);
		end
		for (int m = 0; m < 4; m++) begin
			repeat (blockCount) runInstr(makeBlock(2'(m)), 1'b0); // DA, IA, DB, IB
		end
		runInstr(32'he8b0ffff, 1'b0); // LDMIA r0!, full list, longest series
		repeat (singleCount) runInstr(makeSingle(), 1'b0);
		repeat (stallCount) runInstr(makeAny(), 1'b1);
		@(negedge clk);
		@(negedge clk); // Let the last edge and assertions settle
		if (dut_i.fsm_i.asserts_i.failCount == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			abortRun("a protocol assertion failed");
		end
	end
endmodule

`default_nettype wire

// ==== verification/microOpSequencer_asserts.sv ====
`default_nettype none

module microOpSequencer_asserts (
	input logic clk,
	input logic reset,
	input logic stallUop,
	input logic uOpStall,
	input uopSeqPkg::uopStep step
);
	int failCount = 0; // Failed checks so far
	int stallRun; // Unstalled cycles in a row with fetch held

	always_ff @(posedge clk) begin
		if (reset) begin
			stallRun <= 0;
		end else if (!uOpStall) begin
			stallRun <= 0; // Series ended
		end else if (!stallUop) begin
			stallRun <= stallRun + 1;
		end
	end

	idleAfterReset: assert property (@(posedge clk) $fell(reset) |-> !uOpStall)
		else begin
			failCount = failCount + 1;
			$error("uOpStall high in the first cycle after reset");
		end

	// Longest series is 16 transfers and a base update
	boundedSeries: assert property (@(posedge clk) disable iff (reset) stallRun <= 17)
		else begin
			failCount = failCount + 1;
			$error("uOpStall held for more than 17 unstalled cycles");
		end

	holdStep: assert property (@(posedge clk) disable iff (reset) stallUop |=> $stable(step))
		else begin
			failCount = failCount + 1;
			$error("micro-op step moved while stallUop was high");
		end
endmodule

bind uopFsm microOpSequencer_asserts asserts_i (
	.clk(clk),
	.reset(reset),
	.stallUop(stallUop),
	.uOpStall(uOpStall),
	.step(step)
);

`default_nettype wire

// ==== rtl/microOpSequencer.sv ====
`default_nettype none

module microOpSequencer (
	input logic clk,
	input logic reset,
	input armInstrPkg::instrWord defaultInstr,
	input logic stallUop,
	output logic instrMux,
	output logic doNotUpdateFlag,
	output logic uOpStall,
	output logic ldmStmForward,
	output logic prevRsrState,
	output logic keepV,
	output uopSeqPkg::rzCtrl regFileRz,
	output armInstrPkg::instrWord uOpInstr
);
	uopSeqPkg::instrKind kind;
	uopSeqPkg::uopStep step;
	uopSeqPkg::regCount remaining;
	uopSeqPkg::startOffset startImm;
	logic [3:0] nextReg;
	logic fromInstr;
	logic addUp;

	instrDecoder decoder_i (
		.defaultInstr(defaultInstr),
		.kind(kind)
	);

	regListTracker tracker_i (
		.clk(clk),
		.reset(reset),
		.advance(~stallUop), // List moves with the FSM
		.fromInstr(fromInstr),
		.defaultInstr(defaultInstr),
		.nextReg(nextReg),
		.remaining(remaining),
		.startImm(startImm),
		.addUp(addUp)
	);

	uopFsm fsm_i (
		.clk(clk),
		.reset(reset),
		.stallUop(stallUop),
		.kind(kind),
		.remaining(remaining),
		.writeBack(defaultInstr[armInstrPkg::wBit]),
		.fromInstr(fromInstr),
		.step(step),
		.uOpStall(uOpStall)
	);

	uopEncoder encoder_i (
		.defaultInstr(defaultInstr),
		.step(step),
		.nextReg(nextReg),
		.startImm(startImm),
		.addUp(addUp),
		.remaining(remaining),
		.uOpInstr(uOpInstr),
		.instrMux(instrMux),
		.doNotUpdateFlag(doNotUpdateFlag),
		.ldmStmForward(ldmStmForward),
		.prevRsrState(prevRsrState),
		.keepV(keepV),
		.regFileRz(regFileRz)
	);
endmodule

`default_nettype wire

// ==== rtl/uopEncoder.sv ====
`default_nettype none

module uopEncoder (
	input armInstrPkg::instrWord defaultInstr,
	input uopSeqPkg::uopStep step,
	input logic [3:0] nextReg,
	input uopSeqPkg::startOffset startImm,
	input logic addUp,
	input uopSeqPkg::regCount remaining,
	output armInstrPkg::instrWord uOpInstr,
	output logic instrMux,
	output logic doNotUpdateFlag,
	output logic ldmStmForward,
	output logic prevRsrState,
	output logic keepV,
	output uopSeqPkg::rzCtrl regFileRz
);
	logic [3:0] cond;
	logic [3:0] baseReg;
	logic [3:0] wbOp;

	assign cond = defaultInstr[armInstrPkg::condLsb +: 4];
	assign baseReg = defaultInstr[armInstrPkg::rnLsb +: 4];
	assign wbOp = addUp ? armInstrPkg::opAdd : armInstrPkg::opSub; // Follows the U bit

	always_comb begin
		uOpInstr = defaultInstr;
		instrMux = (step != uopSeqPkg::passThrough); // Any micro-op replaces the word
		doNotUpdateFlag = 1'b0;
		ldmStmForward = 1'b0;
		prevRsrState = 1'b0;
		keepV = 1'b0;
		regFileRz = uopSeqPkg::rzNone;
		case (step)
			uopSeqPkg::rsrShift: begin // MOV Rz, Rm shift Rs
				uOpInstr = {cond, armInstrPkg::classDp, armInstrPkg::opMov, 1'b0, 4'd0,
					armInstrPkg::rzIndex, defaultInstr[11:0]};
				doNotUpdateFlag = 1'b1; // Shift carry must not reach CPSR
				regFileRz = uopSeqPkg::rzShiftDst;
			end
			uopSeqPkg::rsrExec: begin
				uOpInstr = {defaultInstr[31:12], 8'd0, armInstrPkg::rzIndex}; // Op on Rz unshifted
				prevRsrState = 1'b1;
				regFileRz = uopSeqPkg::rzOnRa2;
			end
			uopSeqPkg::mlaMul: begin // MUL Rz, Rm, Rs with no flags
				uOpInstr = {cond, 8'd0, armInstrPkg::rzIndex, 4'd0, defaultInstr[11:0]};
				keepV = 1'b1;
				regFileRz = uopSeqPkg::rzShiftDst;
			end
			uopSeqPkg::mlaAcc: begin
				// MLA keeps Rd in [19:16] and Rn in [15:12]
				uOpInstr = {cond, armInstrPkg::classDp, armInstrPkg::opAdd,
					defaultInstr[armInstrPkg::sBit], armInstrPkg::rzIndex,
					defaultInstr[armInstrPkg::rnLsb +: 4], 8'd0,
					defaultInstr[armInstrPkg::rdLsb +: 4]};
				doNotUpdateFlag = 1'b1;
				prevRsrState = 1'b1;
				regFileRz = uopSeqPkg::rzOnRa1;
			end
			uopSeqPkg::linkSave: begin // SUB lr, pc, #4
				uOpInstr = {cond, armInstrPkg::classDpImm, armInstrPkg::opSub, 1'b0, 4'd15,
					4'd14, armInstrPkg::pcOffsetWord};
			end
			uopSeqPkg::branchPlain: uOpInstr = {defaultInstr[31:25], 1'b0, defaultInstr[23:0]};
			uopSeqPkg::branchExch: uOpInstr = {defaultInstr[31:6], 1'b0, defaultInstr[4:0]}; // BX
			uopSeqPkg::multiFirst: begin // Pre-indexed word transfer off Rn without writeback
				uOpInstr = {cond, armInstrPkg::classSingle, 1'b1, addUp, 2'b00,
					defaultInstr[armInstrPkg::lBit], baseReg, nextReg, startImm};
				doNotUpdateFlag = 1'b1;
			end
			uopSeqPkg::multiNext: begin // Next word above the last with its address in Rz
				uOpInstr = {cond, armInstrPkg::classSingle, 1'b1, 1'b1, 2'b00,
					defaultInstr[armInstrPkg::lBit], armInstrPkg::rzIndex, nextReg,
					armInstrPkg::pcOffsetWord};
				doNotUpdateFlag = 1'b1;
				ldmStmForward = 1'b1; // Previous address forwarded into Rz
				regFileRz = uopSeqPkg::rzOnRa1;
			end
			uopSeqPkg::multiFiller: begin
				uOpInstr = {armInstrPkg::condNever, armInstrPkg::classDpImm, armInstrPkg::opAdd,
					1'b0, 20'd0};
				doNotUpdateFlag = 1'b1;
			end
			uopSeqPkg::multiWriteback: begin // Rn = Rn +/- count ror 30
				uOpInstr = {cond, armInstrPkg::classDpImm, wbOp, 1'b0, baseReg, baseReg, 4'hf,
					3'd0, remaining};
				doNotUpdateFlag = 1'b1;
			end
			default: ;
		endcase
	end
endmodule

`default_nettype wire

// ==== rtl/uopFsm.sv ====
`default_nettype none

module uopFsm (
	input logic clk,
	input logic reset,
	input logic stallUop,
	input uopSeqPkg::instrKind kind,
	input uopSeqPkg::regCount remaining,
	input logic writeBack,
	output logic fromInstr,
	output uopSeqPkg::uopStep step,
	output logic uOpStall
);
	uopSeqPkg::seqState state;
	uopSeqPkg::seqState nextState;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uopSeqPkg::ready;
		end else if (!stallUop) begin
			state <= nextState; // Frozen while the pipeline holds
		end
	end

	always_comb begin
		nextState = uopSeqPkg::ready;
		step = uopSeqPkg::passThrough;
		case (state)
			uopSeqPkg::ready: begin
				case (kind)
					uopSeqPkg::rsr: begin
						nextState = uopSeqPkg::rsrOp;
						step = uopSeqPkg::rsrShift;
					end
					uopSeqPkg::mla: begin
						nextState = uopSeqPkg::mlaAdd;
						step = uopSeqPkg::mlaMul;
					end
					uopSeqPkg::bl: begin
						nextState = uopSeqPkg::branch;
						step = uopSeqPkg::linkSave;
					end
					uopSeqPkg::blx: begin
						nextState = uopSeqPkg::branchX;
						step = uopSeqPkg::linkSave;
					end
					uopSeqPkg::ldm, uopSeqPkg::stm: begin
						nextState = uopSeqPkg::multi; // Even a one-register list
						step = uopSeqPkg::multiFirst;
					end
					default: ;
				endcase
			end
			uopSeqPkg::rsrOp: step = uopSeqPkg::rsrExec;
			uopSeqPkg::mlaAdd: step = uopSeqPkg::mlaAcc;
			uopSeqPkg::branch: step = uopSeqPkg::branchPlain;
			uopSeqPkg::branchX: step = uopSeqPkg::branchExch;
			uopSeqPkg::multi: begin
				if (remaining == 5'd0) begin
					step = uopSeqPkg::multiFiller; // Single register was sent first
				end else begin
					step = uopSeqPkg::multiNext;
					if (remaining == 5'd1) begin
						nextState = writeBack ? uopSeqPkg::multiWb : uopSeqPkg::ready;
					end else begin
						nextState = uopSeqPkg::multi;
					end
				end
			end
			uopSeqPkg::multiWb: step = uopSeqPkg::multiWriteback;
			default: ;
		endcase
	end

	// Tracker reads the list from the word at series start and for the base update
	assign fromInstr = (state == uopSeqPkg::ready) || (state == uopSeqPkg::multiWb);
	assign uOpStall = (nextState != uopSeqPkg::ready); // Keep fetch on this word
endmodule

`default_nettype wire

// ==== rtl/regListTracker.sv ====
`default_nettype none

module regListTracker (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic fromInstr,
	input armInstrPkg::instrWord defaultInstr,
	output logic [3:0] nextReg,
	output uopSeqPkg::regCount remaining,
	output uopSeqPkg::startOffset startImm,
	output logic addUp
);
	logic [armInstrPkg::regListWidth-1:0] listNow; // Registers still to transfer
	logic [armInstrPkg::regListWidth-1:0] activeList;
	uopSeqPkg::regCount lessOne;

	// First cycle of a block transfer works on the full list
	assign activeList = fromInstr ? defaultInstr[armInstrPkg::regListWidth-1:0] : listNow;

	always_ff @(posedge clk) begin
		if (reset) begin
			listNow <= '0;
		end else if (advance) begin
			listNow <= activeList & (activeList - 1'b1); // Drop the register sent now
		end
	end

	// Lowest set bit wins, so transfers go in ascending order
	always_comb begin
		nextReg = '0;
		for (int i = armInstrPkg::regListWidth - 1; i >= 0; i--) begin
			if (activeList[i]) begin
				nextReg = 4'(i);
			end
		end
	end

	assign remaining = uopSeqPkg::regCount'($countones(activeList));
	assign lessOne = remaining - 5'd1;
	assign addUp = defaultInstr[armInstrPkg::uBit];

	// Offset from Rn to the lowest address of the block
	always_comb begin
		case ({defaultInstr[armInstrPkg::pBit], defaultInstr[armInstrPkg::uBit]})
			2'b00: startImm = {5'd0, lessOne, 2'b00}; // DA, Rn - 4n + 4
			2'b01: startImm = '0; // IA, Rn itself
			2'b10: startImm = {5'd0, remaining, 2'b00}; // DB, Rn - 4n
			default: startImm = armInstrPkg::pcOffsetWord; // IB, Rn + 4
		endcase
	end
endmodule

`default_nettype wire

// ==== rtl/instrDecoder.sv ====
`default_nettype none

module instrDecoder (
	input armInstrPkg::instrWord defaultInstr,
	output uopSeqPkg::instrKind kind
);
	logic isMla;
	logic isRsr;
	logic isBl;
	logic isBlx;
	logic isBlock;

	assign isMla = (defaultInstr[27:21] == armInstrPkg::mlaCode)
		&& (defaultInstr[7:4] == armInstrPkg::mulPattern); // Short accumulate only
	// Register shift amount, bit 7 low keeps multiplies out
	assign isRsr = (defaultInstr[27:25] == armInstrPkg::classDp) && !defaultInstr[7]
		&& defaultInstr[4]
		&& (defaultInstr[27:6] != armInstrPkg::blxPattern[23:2]); // Not BX/BLX
	assign isBl = (defaultInstr[27:24] == {armInstrPkg::classBranch, 1'b1}); // Link bit set
	assign isBlx = (defaultInstr[27:4] == armInstrPkg::blxPattern); // Register form
	assign isBlock = (defaultInstr[27:25] == armInstrPkg::classBlock);

	always_comb begin
		if (isMla) begin
			kind = uopSeqPkg::mla;
		end else if (isRsr) begin
			kind = uopSeqPkg::rsr;
		end else if (isBl) begin
			kind = uopSeqPkg::bl;
		end else if (isBlx) begin
			kind = uopSeqPkg::blx;
		end else if (isBlock) begin
			kind = defaultInstr[armInstrPkg::lBit] ? uopSeqPkg::ldm : uopSeqPkg::stm;
		end else begin
			kind = uopSeqPkg::plain; // Goes through untouched
		end
	end
endmodule

`default_nettype wire

// ==== rtl/uopSeqPkg.sv ====
`default_nettype none

package uopSeqPkg;
	// Instructions the decoder picks out for expansion
	typedef enum logic [2:0] {plain, rsr, mla, bl, blx, ldm, stm} instrKind;

	typedef enum logic [2:0] {
		ready, // Next word starts a new series
		rsrOp, // Operation on Rz pending
		mlaAdd, // Accumulate pending
		branch, // Plain branch pending
		branchX, // BX pending
		multi, // Block transfer running
		multiWb // Base update pending
	} seqState;

	typedef enum logic [3:0] {
		passThrough, rsrShift, rsrExec, mlaMul, mlaAcc, linkSave, branchPlain,
		branchExch, multiFirst, multiNext, multiFiller, multiWriteback
	} uopStep;

	// Bit 3 steers the RA1 mux, bits 2..0 force Rz on WA3, RA2 and RA1
	typedef logic [3:0] rzCtrl;
	typedef logic [4:0] regCount; // 0..16 registers
	typedef logic [11:0] startOffset;

	localparam rzCtrl rzNone = 4'b0000;
	localparam rzCtrl rzShiftDst = 4'b1100; // Result written to Rz
	localparam rzCtrl rzOnRa2 = 4'b0010; // Rz read as second operand
	localparam rzCtrl rzOnRa1 = 4'b0001; // Rz read as first operand or base
endpackage

`default_nettype wire

// ==== rtl/armInstrPkg.sv ====
`default_nettype none

package armInstrPkg;
	typedef logic [31:0] instrWord;

	localparam int condLsb = 28; // Condition field [31:28]
	localparam int rnLsb = 16; // Rn on data processing and transfers
	localparam int rdLsb = 12; // Rd on data processing and transfers
	localparam int pBit = 24; // Pre-index
	localparam int uBit = 23; // Up, add the offset
	localparam int wBit = 21; // Base writeback
	localparam int sBit = 20; // Set flags, data processing and multiply
	localparam int lBit = 20; // Load, transfers only
	localparam int regListWidth = 16;

	localparam logic [3:0] opMov = 4'b1101;
	localparam logic [3:0] opAdd = 4'b0100;
	localparam logic [3:0] opSub = 4'b0010;

	localparam logic [2:0] classDp = 3'b000; // Register operand, multiply, BX/BLX
	localparam logic [2:0] classDpImm = 3'b001; // Rotated immediate operand
	localparam logic [2:0] classSingle = 3'b010; // LDR/STR with 12-bit immediate
	localparam logic [2:0] classBlock = 3'b100; // LDM/STM
	localparam logic [2:0] classBranch = 3'b101; // B and BL, bit 24 is the link

	localparam logic [6:0] mlaCode = 7'b0000001; // Bits [27:21] of MLA
	localparam logic [3:0] mulPattern = 4'b1001; // Bits [7:4] of every multiply
	localparam logic [23:0] blxPattern = {8'b0001_0010, 12'hfff, 4'b0011}; // Bits [27:4]
	localparam logic [3:0] condNever = 4'b1111; // NV, never executes

	localparam logic [3:0] rzIndex = 4'd15; // Register field value that selects Rz
	localparam logic [11:0] pcOffsetWord = 12'd4; // One word
endpackage

`default_nettype wire
